/* Bender.yml */
package:
  name: axi3_read_slice

sources:
  - target: any(rtl, test)
    files:
      - verilog/axi3_slice_pkg.sv
      - verilog/axi_slice_stage.sv
      - verilog/reset_release_pipe.sv
      - verilog/axi3_read_slice.sv
  - target: test
    files:
      - testbench/axi3_read_slice_sva.sv
      - testbench/axi3_read_slice_tb.sv

/* sim.f */
verilog/axi3_slice_pkg.sv
verilog/axi_slice_stage.sv
verilog/reset_release_pipe.sv
verilog/axi3_read_slice.sv
testbench/axi3_read_slice_sva.sv
testbench/axi3_read_slice_tb.sv

/* testbench/axi3_read_slice_sva.sv */
`default_nettype none

module axi3_read_slice_sva (
    input logic                        aclk,
    input logic                        rst_n,
    input logic                        s_arvalid,
    input logic                        s_arready,
    input axi3_slice_pkg::ar_payload_t ar_in,
    input logic                        m_arvalid,
    input logic                        m_arready,
    input axi3_slice_pkg::ar_payload_t ar_out,
    input logic                        m_rvalid,
    input logic                        m_rready,
    input axi3_slice_pkg::r_payload_t  r_in,
    input logic                        s_rvalid,
    input logic                        s_rready,
    input axi3_slice_pkg::r_payload_t  r_out
);

    // Read by the testbench at the end of the run
    int unsigned assert_fails = 0;

    // ==================================================
    // Valid and payload hold until the handshake
    // ==================================================

    s_ar_hold : assert property (@(posedge aclk) disable iff (!rst_n)
        s_arvalid && !s_arready |=> s_arvalid && $stable(ar_in))
    else begin
        assert_fails++;
        $error("s_ar valid or payload changed while waiting for s_arready");
    end

    m_ar_hold : assert property (@(posedge aclk) disable iff (!rst_n)
        m_arvalid && !m_arready |=> m_arvalid && $stable(ar_out))
    else begin
        assert_fails++;
        $error("m_ar valid or payload changed while waiting for m_arready");
    end

    m_r_hold : assert property (@(posedge aclk) disable iff (!rst_n)
        m_rvalid && !m_rready |=> m_rvalid && $stable(r_in))
    else begin
        assert_fails++;
        $error("m_r valid or payload changed while waiting for m_rready");
    end

    s_r_hold : assert property (@(posedge aclk) disable iff (!rst_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(r_out))
    else begin
        assert_fails++;
        $error("s_r valid or payload changed while waiting for s_rready");
    end

    // ==================================================
    // Outputs stay idle in reset
    // ==================================================

    idle_in_reset : assert property (@(posedge aclk) !rst_n |-> !m_arvalid && !s_rvalid)
    else begin
        assert_fails++;
        $error("m_arvalid or s_rvalid high while rst_n is low");
    end

endmodule

bind axi3_read_slice axi3_read_slice_sva sva_i (
    .aclk      ( aclk ),
    .rst_n     ( rst_n ),
    .s_arvalid ( s_arvalid ),
    .s_arready ( s_arready ),
    .ar_in     ( ar_in ),
    .m_arvalid ( m_arvalid ),
    .m_arready ( m_arready ),
    .ar_out    ( ar_out ),
    .m_rvalid  ( m_rvalid ),
    .m_rready  ( m_rready ),
    .r_in      ( r_in ),
    .s_rvalid  ( s_rvalid ),
    .s_rready  ( s_rready ),
    .r_out     ( r_out )
);

`default_nettype wire

/* testbench/axi3_read_slice_tb.sv */
`default_nettype none

module axi3_read_slice_tb;

    import axi3_slice_pkg::*;

    localparam int BEATS_PER_CHANNEL = 200;
    localparam int TIMEOUT_CYCLES    = BEATS_PER_CHANNEL * 4 + 100;
    localparam int DRIVE_DELAY       = 2;
    localparam int FLOW_LATENCY      = 1;
    // The peripheral reset trails rst_n by two edges in the FULL slice
    localparam int FULL_RESET_DEPTH  = 2;

    logic                aclk;
    logic                rst_n;
    logic                periph_rst_n;
    logic                s_arvalid, s_arready, m_arvalid, m_arready;
    logic                m_rvalid, m_rready, s_rvalid, s_rready;
    logic [ID_WID-1:0]   s_arid, m_arid, m_rid, s_rid;
    logic [ADDR_WID-1:0] s_araddr, m_araddr;
    logic [3:0]          s_arlen, m_arlen;
    logic [2:0]          s_arsize, m_arsize;
    logic [1:0]          s_arburst, m_arburst, m_rresp, s_rresp;
    logic [DATA_WID-1:0] m_rdata, s_rdata;
    logic                m_rlast, s_rlast;

    // Beats as they enter and leave the slice
    ar_payload_t ar_sent, ar_seen;
    r_payload_t  r_sent, r_seen;

    assign ar_sent = '{s_arid, s_araddr, s_arlen, s_arsize, s_arburst};
    assign ar_seen = '{m_arid, m_araddr, m_arlen, m_arsize, m_arburst};
    assign r_sent  = '{m_rid, m_rdata, m_rresp, m_rlast};
    assign r_seen  = '{s_rid, s_rdata, s_rresp, s_rlast};

    logic [15:0] lfsr;
    int          cycle;
    int          value_errors;
    int          other_errors;
    int          ar_left, r_left, burst_left;
    int          m_arready_mode, s_rready_mode;
    bit          back_to_back, flow_on;
    bit          ar_taken, r_taken;
    ar_payload_t ar_q[$];
    r_payload_t  r_q[$];
    int          ar_stamp[$], r_stamp[$];
    bit          ar_timed[$], r_timed[$];

    axi3_read_slice #(
        .slice_config ( SLICE_FULL )
    ) axi3_read_slice_i (.*);

    initial begin
        aclk = 1'b0;
        forever begin
            #10 aclk = ~aclk;
        end
    end

    // ==================================================
    // Random source and reference model
    // ==================================================

    // Fibonacci form with taps at bits 16 14 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Mode 0 holds ready low, 2 holds it high, 1 stalls a quarter of the cycles
    function automatic logic ready_value(input int mode);
        if (mode == 1) begin
            return rand_bits(2) != 0;
        end
        return mode == 2;
    endfunction

    // A register slice is transparent, so every beat leaves exactly as it entered
    function automatic ar_payload_t ar_expected(input ar_payload_t sent);
        return sent;
    endfunction

    function automatic r_payload_t r_expected(input r_payload_t sent);
        return sent;
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================

    task automatic compare_field(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s: expected %0h, got %0h in cycle %0d", name, exp, act, cycle);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        compare_field(name, 64'(exp), 64'(act));
    endtask

    task automatic check_ar(input ar_payload_t exp, input ar_payload_t act);
        compare_field("m_arid", 64'(exp.id), 64'(act.id));
        compare_field("m_araddr", 64'(exp.addr), 64'(act.addr));
        compare_field("m_arlen", 64'(exp.len), 64'(act.len));
        compare_field("m_arsize", 64'(exp.size), 64'(act.size));
        compare_field("m_arburst", 64'(exp.burst), 64'(act.burst));
    endtask

    task automatic check_r(input r_payload_t exp, input r_payload_t act);
        compare_field("s_rid", 64'(exp.id), 64'(act.id));
        compare_field("s_rdata", exp.data, act.data);
        compare_field("s_rresp", 64'(exp.resp), 64'(act.resp));
        compare_field("s_rlast", 64'(exp.last), 64'(act.last));
    endtask

    task automatic check_latency(input string chan, input int stamp, input bit timed);
        if (timed && cycle != stamp + FLOW_LATENCY) begin
            other_errors++;
            $display("%s beat taken in cycle %0d came out %0d cycles later instead of %0d",
                     chan, stamp, cycle - stamp, FLOW_LATENCY);
        end
    endtask

    // ==================================================
    // Controller and peripheral models
    // ==================================================

    task automatic drive_cycle();
        if (!s_arvalid || ar_taken) begin
            if (ar_left > 0 && (back_to_back || rand_bits(2) != 0)) begin
                s_arid    = ID_WID'(rand_bits(ID_WID));
                s_araddr  = ADDR_WID'(rand_bits(ADDR_WID));
                s_arlen   = 4'(rand_bits(4));
                s_arsize  = 3'(rand_bits(3));
                s_arburst = 2'(rand_bits(2));
                s_arvalid = 1'b1;
                ar_left--;
            end else begin
                s_arvalid = 1'b0;
            end
        end
        if (!m_rvalid || r_taken) begin
            if (r_left > 0 && (back_to_back || rand_bits(2) != 0)) begin
                // A new burst gets its own id and a length of one to four beats
                if (burst_left == 0) begin
                    burst_left = int'(rand_bits(2)) + 1;
                    burst_left = (burst_left > r_left) ? r_left : burst_left;
                    m_rid      = ID_WID'(rand_bits(ID_WID));
                end
                m_rdata  = rand_bits(DATA_WID);
                m_rresp  = 2'(rand_bits(2));
                m_rlast  = (burst_left == 1);
                m_rvalid = 1'b1;
                burst_left--;
                r_left--;
            end else begin
                m_rvalid = 1'b0;
            end
        end
        m_arready = ready_value(m_arready_mode);
        s_rready  = ready_value(s_rready_mode);
    endtask

    task automatic run_phase(input string name, input bit need_ar, input bit need_r);
        int limit;
        int spent;
        bit done;
        limit = (ar_left > r_left ? ar_left : r_left) * 4 + 20;
        spent = 0;
        done  = 1'b0;
        while (!done && spent < limit) begin
            @(posedge aclk);
            #DRIVE_DELAY;
            drive_cycle();
            spent++;
            done = (!need_ar || (ar_left == 0 && !s_arvalid && ar_q.size() == 0)) &&
                   (!need_r || (r_left == 0 && !m_rvalid && r_q.size() == 0));
        end
        if (!done) begin
            other_errors++;
            $display("Phase '%s' did not drain within %0d cycles", name, limit);
        end
    endtask

    task automatic check_reset_release();
        int depth;
        depth = FULL_RESET_DEPTH;
        @(negedge aclk);
        check_bit("periph_rst_n", depth == 0, periph_rst_n);
        check_bit("m_arvalid", 1'b0, m_arvalid);
        check_bit("s_rvalid", 1'b0, s_rvalid);
        check_bit("s_arready", 1'b1, s_arready);
        check_bit("m_rready", 1'b1, m_rready);
        for (int k = 1; k <= depth; k++) begin
            @(negedge aclk);
            check_bit("periph_rst_n", k == depth, periph_rst_n);
        end
    endtask

    task automatic print_error_counts();
        $display("Errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
                 axi3_read_slice_i.sva_i.assert_fails);
    endtask

    // ==================================================
    // Comparing processes sample at the falling edge
    // ==================================================

    always @(negedge aclk) begin
        if (rst_n) begin
            if (s_arvalid && s_arready) begin
                ar_q.push_back(ar_sent);
                ar_stamp.push_back(cycle);
                ar_timed.push_back(flow_on);
            end
            if (flow_on && s_arvalid) begin
                check_bit("s_arready", 1'b1, s_arready);
            end
            if (m_arvalid && m_arready) begin
                if (ar_q.size() == 0) begin
                    other_errors++;
                    $display("AR beat left the slice in cycle %0d with none outstanding", cycle);
                end else begin
                    check_ar(ar_expected(ar_q.pop_front()), ar_seen);
                    check_latency("AR", ar_stamp.pop_front(), ar_timed.pop_front());
                end
            end
        end
        ar_taken = rst_n && s_arvalid && s_arready;
    end

    always @(negedge aclk) begin
        if (rst_n) begin
            if (m_rvalid && m_rready) begin
                r_q.push_back(r_sent);
                r_stamp.push_back(cycle);
                r_timed.push_back(flow_on);
            end
            if (flow_on && m_rvalid) begin
                check_bit("m_rready", 1'b1, m_rready);
            end
            if (s_rvalid && s_rready) begin
                if (r_q.size() == 0) begin
                    other_errors++;
                    $display("R beat left the slice in cycle %0d with none outstanding", cycle);
                end else begin
                    check_r(r_expected(r_q.pop_front()), r_seen);
                    check_latency("R", r_stamp.pop_front(), r_timed.pop_front());
                end
            end
        end
        r_taken = rst_n && m_rvalid && m_rready;
    end

    initial begin
        cycle = 0;
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge aclk);
            cycle++;
        end
        $display("Run stopped after %0d cycles with %0d AR and %0d R beats outstanding",
                 cycle, ar_q.size(), r_q.size());
        print_error_counts();
        $display("test failed");
        $finish;
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        lfsr           = 16'd56680;
        value_errors   = 0;
        other_errors   = 0;
        ar_left        = 0;
        r_left         = 0;
        burst_left     = 0;
        back_to_back   = 1'b0;
        flow_on        = 1'b0;
        m_arready_mode = 2;
        s_rready_mode  = 2;
        {s_arid, s_araddr, s_arlen, s_arsize, s_arburst, s_arvalid} = '0;
        {m_rid, m_rdata, m_rresp, m_rlast, m_rvalid} = '0;
        m_arready = 1'b0;
        s_rready  = 1'b0;
        rst_n     = 1'b1;
        #1;
        rst_n = 1'b0;
        repeat (5) @(posedge aclk);
        check_bit("periph_rst_n", 1'b0, periph_rst_n);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        check_reset_release();

        // Random valid gaps against random stalls on both ready inputs
        m_arready_mode = 1;
        s_rready_mode  = 1;
        ar_left        = 100;
        r_left         = 100;
        run_phase("random traffic", 1'b1, 1'b1);

        // A back-to-back stream with ready held high takes one cycle through the slice
        back_to_back   = 1'b1;
        flow_on        = 1'b1;
        m_arready_mode = 2;
        s_rready_mode  = 2;
        ar_left        = 40;
        r_left         = 40;
        run_phase("back-to-back", 1'b1, 1'b1);
        back_to_back = 1'b0;
        flow_on      = 1'b0;

        // AR keeps moving while the controller holds R, then the reverse
        m_arready_mode = 1;
        s_rready_mode  = 0;
        ar_left        = 25;
        r_left         = 5;
        run_phase("AR with R stalled", 1'b1, 1'b0);
        s_rready_mode = 1;
        run_phase("R release", 1'b1, 1'b1);
        m_arready_mode = 0;
        ar_left        = 5;
        r_left         = 25;
        run_phase("R with AR stalled", 1'b0, 1'b1);
        m_arready_mode = 1;
        run_phase("AR release", 1'b1, 1'b1);

        if (ar_q.size() != 0 || r_q.size() != 0) begin
            other_errors++;
            $display("%0d AR and %0d R beats never came out of the slice",
                     ar_q.size(), r_q.size());
        end
        print_error_counts();
        if (value_errors == 0 && other_errors == 0 &&
            axi3_read_slice_i.sva_i.assert_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/axi3_read_slice.sv */
`default_nettype none

module axi3_read_slice #(
    parameter axi3_slice_pkg::slice_config_t slice_config = axi3_slice_pkg::SLICE_FULL
) (
    input  logic                                aclk,
    input  logic                                rst_n,

    // Read address from the controller
    input  logic [axi3_slice_pkg::ID_WID-1:0]   s_arid,
    input  logic [axi3_slice_pkg::ADDR_WID-1:0] s_araddr,
    input  logic [3:0]                          s_arlen,
    input  logic [2:0]                          s_arsize,
    input  logic [1:0]                          s_arburst,
    input  logic                                s_arvalid,
    output logic                                s_arready,

    // Read address to the peripheral
    output logic [axi3_slice_pkg::ID_WID-1:0]   m_arid,
    output logic [axi3_slice_pkg::ADDR_WID-1:0] m_araddr,
    output logic [3:0]                          m_arlen,
    output logic [2:0]                          m_arsize,
    output logic [1:0]                          m_arburst,
    output logic                                m_arvalid,
    input  logic                                m_arready,

    // Read data from the peripheral
    input  logic [axi3_slice_pkg::ID_WID-1:0]   m_rid,
    input  logic [axi3_slice_pkg::DATA_WID-1:0] m_rdata,
    input  logic [1:0]                          m_rresp,
    input  logic                                m_rlast,
    input  logic                                m_rvalid,
    output logic                                m_rready,

    // Read data to the controller
    output logic [axi3_slice_pkg::ID_WID-1:0]   s_rid,
    output logic [axi3_slice_pkg::DATA_WID-1:0] s_rdata,
    output logic [1:0]                          s_rresp,
    output logic                                s_rlast,
    output logic                                s_rvalid,
    input  logic                                s_rready,

    output logic                                periph_rst_n
);

    import axi3_slice_pkg::*;

    // ================================================
    // Read address channel
    // ================================================

    ar_payload_t ar_in;
    ar_payload_t ar_out;

    assign ar_in = '{
        id:    s_arid,
        addr:  s_araddr,
        len:   s_arlen,
        size:  s_arsize,
        burst: s_arburst
    };

    axi_slice_stage #(
        .payload_t    ( ar_payload_t ),
        .slice_config ( slice_config )
    ) ar_stage_i (
        .aclk      ( aclk ),
        .rst_n     ( rst_n ),
        .in_valid  ( s_arvalid ),
        .in_ready  ( s_arready ),
        .in_data   ( ar_in ),
        .out_valid ( m_arvalid ),
        .out_ready ( m_arready ),
        .out_data  ( ar_out )
    );

    assign m_arid    = ar_out.id;
    assign m_araddr  = ar_out.addr;
    assign m_arlen   = ar_out.len;
    assign m_arsize  = ar_out.size;
    assign m_arburst = ar_out.burst;

    // ================================================
    // Read data channel
    // ================================================

    r_payload_t r_in;
    r_payload_t r_out;

    // R flows from the peripheral back to the controller
    assign r_in = '{
        id:   m_rid,
        data: m_rdata,
        resp: m_rresp,
        last: m_rlast
    };

    axi_slice_stage #(
        .payload_t    ( r_payload_t ),
        .slice_config ( slice_config )
    ) r_stage_i (
        .aclk      ( aclk ),
        .rst_n     ( rst_n ),
        .in_valid  ( m_rvalid ),
        .in_ready  ( m_rready ),
        .in_data   ( r_in ),
        .out_valid ( s_rvalid ),
        .out_ready ( s_rready ),
        .out_data  ( r_out )
    );

    assign s_rid   = r_out.id;
    assign s_rdata = r_out.data;
    assign s_rresp = r_out.resp;
    assign s_rlast = r_out.last;

    // ================================================
    // Peripheral reset
    // ================================================

    // Both stages run on rst_n directly, so they are empty before the peripheral wakes up
    reset_release_pipe #(
        .stages ( reset_stages(slice_config) )
    ) reset_pipe_i (
        .aclk         ( aclk ),
        .rst_n        ( rst_n ),
        .periph_rst_n ( periph_rst_n )
    );

endmodule

`default_nettype wire

/* verilog/axi3_slice_pkg.sv */
`default_nettype none

package axi3_slice_pkg;

    // ================================================
    // Bus widths
    // ================================================

    localparam int ID_WID   = 4;
    localparam int ADDR_WID = 32;
    localparam int DATA_WID = 64;

    // ================================================
    // Slice kinds and channel payloads
    // ================================================

    // BYPASS is plain wiring, LIGHT a single register and FULL a skid buffer
    typedef enum logic [1:0] {
        SLICE_BYPASS = 2'd0,
        SLICE_LIGHT  = 2'd1,
        SLICE_FULL   = 2'd2
    } slice_config_t;

    // Read address beat, AXI3 field widths
    typedef struct packed {
        logic [ID_WID-1:0]   id;
        logic [ADDR_WID-1:0] addr;
        logic [3:0]          len;
        logic [2:0]          size;
        logic [1:0]          burst;
    } ar_payload_t;

    // Read data beat
    typedef struct packed {
        logic [ID_WID-1:0]   id;
        logic [DATA_WID-1:0] data;
        logic [1:0]          resp;
        logic                last;
    } r_payload_t;

    // Number of aclk edges between reset release and the peripheral leaving reset
    function automatic int reset_stages(input slice_config_t cfg);
        case (cfg)
            SLICE_BYPASS : return 0;
            default      : return 2;
        endcase
    endfunction

endpackage

`default_nettype wire

/* verilog/axi_slice_stage.sv */
`default_nettype none

module axi_slice_stage #(
    parameter type payload_t = logic,
    parameter axi3_slice_pkg::slice_config_t slice_config = axi3_slice_pkg::SLICE_FULL
) (
    input  logic     aclk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    import axi3_slice_pkg::*;

    generate
        if (slice_config == SLICE_FULL) begin : g_full

            // ================================================
            // Two-entry skid buffer
            // ================================================

            logic     main_valid;
            payload_t main_data;
            logic     skid_valid;
            payload_t skid_data;
            logic     main_free;
            logic     in_fire;

            // The output register can take a new beat this cycle
            assign main_free = ~main_valid | out_ready;

            // in_ready comes straight from the skid flop, so it is a register
            assign in_ready = ~skid_valid;
            assign in_fire  = in_valid & ~skid_valid;

            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    main_valid <= 1'b0;
                    skid_valid <= 1'b0;
                end else begin
                    if (main_free) begin
                        // A parked beat always goes out before any new one
                        if (skid_valid) begin
                            main_valid <= 1'b1;
                            skid_valid <= 1'b0;
                        end else begin
                            main_valid <= in_fire;
                        end
                    end else if (in_fire) begin
                        // Output stalled, so the accepted beat parks in the skid entry
                        skid_valid <= 1'b1;
                    end
                end
            end

            // Payload registers follow the valid bits and need no reset
            always_ff @(posedge aclk) begin
                if (main_free) begin
                    if (skid_valid) begin
                        main_data <= skid_data;
                    end else if (in_fire) begin
                        main_data <= in_data;
                    end
                end else if (in_fire) begin
                    skid_data <= in_data;
                end
            end

            assign out_valid = main_valid;
            assign out_data  = main_data;

        end else if (slice_config == SLICE_LIGHT) begin : g_light

            // ================================================
            // Single entry, half throughput
            // ================================================

            logic     full;
            payload_t data_q;

            // Only an empty entry accepts a beat
            assign in_ready = ~full;

            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    full <= 1'b0;
                end else if (full) begin
                    if (out_ready) begin
                        full <= 1'b0;
                    end
                end else if (in_valid) begin
                    full <= 1'b1;
                end
            end

            always_ff @(posedge aclk) begin
                if (!full && in_valid) begin
                    data_q <= in_data;
                end
            end

            assign out_valid = full;
            assign out_data  = data_q;

        end else begin : g_bypass

            // No register at all, zero latency
            assign out_valid = in_valid;
            assign out_data  = in_data;
            assign in_ready  = out_ready;

        end
    endgenerate

endmodule

`default_nettype wire

/* verilog/reset_release_pipe.sv */
`default_nettype none

module reset_release_pipe #(
    parameter int stages = 2
) (
    input  logic aclk,
    input  logic rst_n,
    output logic periph_rst_n
);

    generate
        if (stages == 0) begin : g_pass

            // Nothing to pipeline, the peripheral sees rst_n as it is
            assign periph_rst_n = rst_n;

        end else begin : g_pipe

            logic [stages-1:0] pipe;

            // Assertion is asynchronous, release walks a one through the chain
            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    pipe <= '0;
                end else begin
                    pipe[0] <= 1'b1;
                    for (int i = 1; i < stages; i++) begin
                        pipe[i] <= pipe[i-1];
                    end
                end
            end

            // The last bit rises after exactly stages edges
            assign periph_rst_n = pipe[stages-1];

        end
    endgenerate

endmodule

`default_nettype wire
